// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := wb_shared_bus_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/arb_ctrl_regs.sv
`default_nettype none

`include "bus_consts.svh"

module arb_ctrl_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::wb_req_t    req,
    output wb_pkg::wb_rsp_t    rsp,
    output arb_pkg::arb_cfg_t  cfg,
    input  arb_pkg::arb_stat_t stat
);
    import arb_pkg::*;

    localparam int CNT_IW = $clog2(`NUM_MASTERS);

    logic                    ack;
    logic                    sel;
    logic [`DATA_W-1:0]      rd_data;
    logic [`DATA_W-1:0]      rd_next;
    logic [`NUM_MASTERS-1:0] enable;
    logic [`DATA_W-1:0]      grant_cnt [`NUM_MASTERS];
    arb_reg_e                reg_off;

    assign sel     = req.cyc & req.stb & ~ack;
    assign reg_off = arb_reg_e'(req.adr[`REG_OFF_W-1:0]);

    always_comb begin
        case (reg_off)
            REG_ENABLE: rd_next = {{(`DATA_W-`NUM_MASTERS){1'b0}}, enable};
            REG_GRANT_CNT0, REG_GRANT_CNT1, REG_GRANT_CNT2, REG_GRANT_CNT3:
                rd_next = grant_cnt[CNT_IW'(reg_off - REG_GRANT_CNT0)];
            REG_ID:     rd_next = `ARB_ID_VALUE;
            default:    rd_next = '0;
        endcase
    end

    // Only the enable mask takes writes, other offsets just get acked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            enable <= '1;
        end else begin
            ack <= sel;
            if (sel && req.we && reg_off == REG_ENABLE) begin
                enable <= req.dat[`NUM_MASTERS-1:0];
            end
        end
    end

    // One count per new grant, beats inside a held grant are not counted
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            if (!rst_n) begin
                grant_cnt[i] <= '0;
            end else if (stat.grant_start && stat.grant[i]) begin
                grant_cnt[i] <= grant_cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rd_data <= rd_next;
        end
    end

    assign rsp.ack    = ack;
    assign rsp.dat    = rd_data;
    assign cfg.enable = enable;

endmodule

`default_nettype wire

// File: design/arb_pkg.sv
`default_nettype none

`include "bus_consts.svh"

package arb_pkg;

    // Word offsets inside the register block
    typedef enum logic [`REG_OFF_W-1:0] {
        REG_ENABLE     = `REG_OFF_ENABLE,
        REG_GRANT_CNT0 = `REG_OFF_CNT0,
        REG_GRANT_CNT1,
        REG_GRANT_CNT2,
        REG_GRANT_CNT3,
        REG_ID         = `REG_OFF_ID
    } arb_reg_e;

    // Software controls that steer the arbitration
    typedef struct packed {
        logic [`NUM_MASTERS-1:0] enable;
    } arb_cfg_t;

    // Arbiter activity seen by the register block
    typedef struct packed {
        logic [`NUM_MASTERS-1:0] grant;
        logic                    grant_start;
    } arb_stat_t;

endpackage

`default_nettype wire

// File: design/bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Masters that share the bus
`define NUM_MASTERS 4

// Word address and data widths of the Wishbone bus
`define ADDR_W 8
`define DATA_W 32

// SRAM size in words
`define SRAM_DEPTH 64

// The top address bit picks the register block over the SRAM
`define REG_BASE_BIT (`ADDR_W-1)

// Register block word offsets, decoded from the low address bits
`define REG_OFF_W 3
`define REG_OFF_ENABLE 3'd0
`define REG_OFF_CNT0 3'd1
`define REG_OFF_ID 3'd5
`define ARB_ID_VALUE 32'h4152_4231

`endif

// File: design/matrix_arbiter.sv
`default_nettype none

`include "bus_consts.svh"

module matrix_arbiter #(
    parameter int NUM_INPUTS = `NUM_MASTERS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_INPUTS-1:0] request,
    input  logic [NUM_INPUTS-1:0] hold,
    output logic [NUM_INPUTS-1:0] grant
);

    // A set bit prio[j][i] means input j currently wins over input i
    logic [NUM_INPUTS-1:0] prio [NUM_INPUTS];

    logic [NUM_INPUTS-1:0] hold_q;
    logic [NUM_INPUTS-1:0] grant_q;
    logic [NUM_INPUTS-1:0] held;
    logic [NUM_INPUTS-1:0] blocked;
    logic [NUM_INPUTS-1:0] fresh;

    // An input is blocked when any requester above it is also asking
    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < NUM_INPUTS; j++) begin
                blocked[i] = blocked[i] | (prio[j][i] & request[j]);
            end
        end
    end

    assign fresh = request & ~blocked;

    // Hold is sampled a cycle late, so a master that drops cyc in the
    // middle of its ack cycle still owns the bus until that cycle ends
    assign held  = hold_q & grant_q;
    assign grant = (|held) ? held : fresh;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= '0;
            grant_q <= '0;
        end else begin
            hold_q  <= hold;
            grant_q <= grant;
        end
    end

    // Lower index wins after reset, every grant then sinks the winner
    // below all other inputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                for (int j = 0; j < NUM_INPUTS; j++) begin
                    prio[i][j] <= 1'(i < j);
                end
            end
        end else begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                for (int j = 0; j < NUM_INPUTS; j++) begin
                    if (i != j) begin
                        prio[i][j] <= (prio[i][j] & ~grant[i]) | grant[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/wb_master_mux.sv
`default_nettype none

`include "bus_consts.svh"

module wb_master_mux (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::wb_req_t   m_req [`NUM_MASTERS],
    output wb_pkg::wb_rsp_t   m_rsp [`NUM_MASTERS],
    output wb_pkg::wb_req_t   sram_req,
    input  wb_pkg::wb_rsp_t   sram_rsp,
    output wb_pkg::wb_req_t   reg_req,
    input  wb_pkg::wb_rsp_t   reg_rsp,
    input  arb_pkg::arb_cfg_t cfg,
    output arb_pkg::arb_stat_t stat
);
    import wb_pkg::*;

    logic [`NUM_MASTERS-1:0] request;
    logic [`NUM_MASTERS-1:0] hold;
    logic [`NUM_MASTERS-1:0] grant;
    logic [`NUM_MASTERS-1:0] grant_q;
    wb_req_t                 bus_req;
    wb_rsp_t                 sel_rsp;
    logic                    sel_reg;
    bus_state_e              state;
    bus_state_e              state_next;

    // Disabled masters cannot win, but raw cyc still keeps a running grant
    always_comb begin
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            request[i] = m_req[i].cyc & cfg.enable[i];
            hold[i]    = m_req[i].cyc;
        end
    end

    matrix_arbiter #(
        .NUM_INPUTS (`NUM_MASTERS)
    ) u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (request),
        .hold    (hold),
        .grant   (grant)
    );

    always_comb begin
        bus_req = '0;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            if (grant[i]) begin
                bus_req = m_req[i];
            end
        end
    end

    assign sel_reg = bus_req.adr[`REG_BASE_BIT];

    always_comb begin
        sram_req     = bus_req;
        sram_req.stb = bus_req.stb & ~sel_reg;
        reg_req      = bus_req;
        reg_req.stb  = bus_req.stb & sel_reg;
    end

    assign sel_rsp = sel_reg ? reg_rsp : sram_rsp;

    // DONE covers the cycle after ack, when the slave cannot ack again
    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (bus_req.stb) state_next = ACCESS;
            ACCESS: begin
                if (sel_rsp.ack) begin
                    state_next = DONE;
                end else if (!bus_req.cyc) begin
                    state_next = IDLE;
                end
            end
            DONE:    state_next = bus_req.stb ? ACCESS : IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            grant_q <= '0;
        end else begin
            state   <= state_next;
            grant_q <= grant;
        end
    end

    // Only the owner of the bus hears the response
    always_comb begin
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            m_rsp[i].ack = grant[i] & sel_rsp.ack & (state == ACCESS);
            m_rsp[i].dat = grant[i] ? sel_rsp.dat : '0;
        end
    end

    always_comb begin
        stat.grant       = grant;
        stat.grant_start = |(grant & ~grant_q);
    end

endmodule

`default_nettype wire

// File: design/wb_pkg.sv
`default_nettype none

`include "bus_consts.svh"

package wb_pkg;

    // One master's request toward a slave
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`ADDR_W-1:0] adr;
        logic [`DATA_W-1:0] dat;
    } wb_req_t;

    // Slave response, ack is a single-cycle pulse
    typedef struct packed {
        logic               ack;
        logic [`DATA_W-1:0] dat;
    } wb_rsp_t;

    // Access state of the shared bus
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } bus_state_e;

endpackage

`default_nettype wire

// File: design/wb_shared_bus.sv
`default_nettype none

`include "bus_consts.svh"

module wb_shared_bus (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t m_req [`NUM_MASTERS],
    output wb_pkg::wb_rsp_t m_rsp [`NUM_MASTERS]
);
    import wb_pkg::*;
    import arb_pkg::*;

    wb_req_t   sram_req;
    wb_rsp_t   sram_rsp;
    wb_req_t   reg_req;
    wb_rsp_t   reg_rsp;
    arb_cfg_t  cfg;
    arb_stat_t stat;

    wb_master_mux u_mux (
        .clk      (clk),
        .rst_n    (rst_n),
        .m_req    (m_req),
        .m_rsp    (m_rsp),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .cfg      (cfg),
        .stat     (stat)
    );

    // Register block sits in the upper half of the address space
    arb_ctrl_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (reg_req),
        .rsp   (reg_rsp),
        .cfg   (cfg),
        .stat  (stat)
    );

    wb_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

endmodule

`default_nettype wire

// File: design/wb_sram.sv
`default_nettype none

`include "bus_consts.svh"

module wb_sram (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp
);

    localparam int MEM_AW = $clog2(`SRAM_DEPTH);

    logic [`DATA_W-1:0] mem [`SRAM_DEPTH];
    logic [`DATA_W-1:0] rd_data;
    logic               ack;
    logic               sel;
    logic [MEM_AW-1:0]  word;

    // The ack register itself blocks a second ack in the following cycle
    assign sel  = req.cyc & req.stb & ~ack;
    assign word = req.adr[MEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= sel;
        end
    end

    // The beat is written and read at the edge that raises ack
    always_ff @(posedge clk) begin
        if (sel) begin
            if (req.we) begin
                mem[word] <= req.dat;
            end
            rd_data <= mem[word];
        end
    end

    assign rsp.ack = ack;
    assign rsp.dat = rd_data;

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset is held for three clocks and released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/wb_shared_bus_properties.sv
`default_nettype none

`include "bus_consts.svh"

module wb_shared_bus_properties (
    input logic                    clk,
    input logic                    rst_n,
    input wb_pkg::wb_req_t         m_req [`NUM_MASTERS],
    input wb_pkg::wb_rsp_t         m_rsp [`NUM_MASTERS],
    input logic [`NUM_MASTERS-1:0] grant
);
    timeunit 1ns;
    timeprecision 100ps;

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("Grant vector has more than one bit set");

    for (genvar i = 0; i < `NUM_MASTERS; i++) begin : g_master
        // An owner that keeps cyc must still own the bus next cycle
        held_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
            grant[i] && m_req[i].cyc |=> grant[i])
            else $error("Master %0d lost its grant while holding cyc", i);

        ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
            m_rsp[i].ack |-> m_req[i].cyc)
            else $error("Master %0d got an ack without cyc", i);
    end

endmodule

`default_nettype wire

// File: dv/wb_shared_bus_tb.sv
`default_nettype none

`include "bus_consts.svh"

module wb_shared_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import wb_pkg::*;

    localparam int NUM_ROWS   = 15;
    localparam int CLK_PERIOD = 4;

    // One table row, fields per master are indexed by master number
    typedef struct packed {
        logic [3:0]      active;
        logic [3:0]      stall;
        logic [3:0]      we;
        logic [3:0][7:0] adr;
        logic [31:0]     dat;
        logic [3:0][1:0] beats;
        logic [31:0]     exp;
    } row_t;

    logic        clk;
    logic        rst_n;
    wb_req_t     m_req [`NUM_MASTERS];
    wb_rsp_t     m_rsp [`NUM_MASTERS];
    row_t        rows [$];
    logic [31:0] sb [`SRAM_DEPTH];
    int          lrg_order [$];
    logic [3:0]  en_model;
    int          cnt_model [4];
    int          cnt_snap [4];
    int          ack_log [$];
    int          exp_log [$];
    logic [3:0]  done;
    logic [31:0] lcg_state;
    int          data_errs;
    int          lat_errs;
    int          order_errs;
    int          other_errs;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wb_shared_bus DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .m_req (m_req),
        .m_rsp (m_rsp)
    );

    bind wb_shared_bus wb_shared_bus_properties u_props (
        .clk   (clk),
        .rst_n (rst_n),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .grant (stat.grant)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic row_t make_row(input logic [3:0] active, input logic [3:0] stall,
                                      input logic [3:0] we, input logic [3:0][7:0] adr,
                                      input logic [31:0] dat, input logic [3:0][1:0] beats,
                                      input logic [31:0] exp);
        row_t r;
        r.active = active;
        r.stall  = stall;
        r.we     = we;
        r.adr    = adr;
        r.dat    = dat;
        r.beats  = beats;
        r.exp    = exp;
        return r;
    endfunction

    // Counters read back the value from before the current row started
    function automatic logic [31:0] expected_read(input logic [7:0] adr,
                                                  input logic [31:0] row_exp);
        if (!adr[`REG_BASE_BIT]) begin
            return sb[adr[5:0]];
        end
        case (adr[2:0])
            3'd0:                   return {28'd0, en_model};
            3'd1, 3'd2, 3'd3, 3'd4: return 32'(cnt_snap[adr[2:0] - 3'd1]);
            default:                return row_exp;
        endcase
    endfunction

    // Least-recently-granted: the winner moves to the back of the list
    task automatic grant_model(input int m);
        int idx;
        idx = 0;
        for (int k = 0; k < lrg_order.size(); k++) begin
            if (lrg_order[k] == m) idx = k;
        end
        lrg_order.delete(idx);
        lrg_order.push_back(m);
        cnt_model[m]++;
    endtask

    task automatic predict_order(input row_t r);
        int snap [$];
        exp_log.delete();
        snap = lrg_order;
        foreach (snap[k]) begin
            int m;
            m = snap[k];
            if (r.active[m] && !r.stall[m]) begin
                repeat (r.beats[m]) exp_log.push_back(m);
                if (r.we[m] && r.adr[m][`REG_BASE_BIT] && r.adr[m][2:0] == 3'd0) begin
                    en_model = r.dat[3:0];
                end
                grant_model(m);
            end
        end
        if (r.stall != 4'h0) begin
            // Master 0 writes the full enable mask, then the stalled ones go
            exp_log.push_back(0);
            en_model = 4'hf;
            grant_model(0);
            snap = lrg_order;
            foreach (snap[k]) begin
                if (r.stall[snap[k]]) begin
                    repeat (r.beats[snap[k]]) exp_log.push_back(snap[k]);
                    grant_model(snap[k]);
                end
            end
        end
    endtask

    task automatic do_beats(input int m, input row_t r);
        logic [7:0]  adr;
        logic [31:0] data;
        logic [31:0] exp;
        int          lat;
        if (!r.active[m]) return;
        for (int b = 0; b < int'(r.beats[m]); b++) begin
            adr  = r.adr[m] + 8'(b);
            data = (r.we[m] && !adr[`REG_BASE_BIT]) ? lcg_next() : r.dat;
            exp  = expected_read(adr, r.exp);
            if (r.we[m] && !adr[`REG_BASE_BIT]) sb[adr[5:0]] = data;
            m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: r.we[m], adr: adr, dat: data};
            lat = 0;
            #1;
            while (!m_rsp[m].ack) begin
                @(negedge clk);
                #1;
                lat++;
            end
            ack_log.push_back(m);
            if (r.active == 4'(1 << m) || b > 0) begin
                assert (lat == 1) else begin
                    lat_errs++;
                    $display("FAIL %0t: master %0d beat %0d acked after %0d cycles",
                             $time, m, b, lat);
                end
            end
            if (!r.we[m]) begin
                assert (m_rsp[m].dat == exp) else begin
                    data_errs++;
                    $display("FAIL %0t: master %0d read %h at %h, expected %h",
                             $time, m, m_rsp[m].dat, adr, exp);
                end
            end
            @(negedge clk);
        end
        m_req[m] = '0;
        done[m]  = 1'b1;
    endtask

    task automatic release_stalled(input row_t r);
        row_t reen;
        if (r.stall == 4'h0) return;
        wait ((done | r.stall) == 4'hf);
        repeat (3) @(negedge clk);
        assert ((done & r.stall) == 4'h0) else begin
            other_errs++;
            $display("A disabled master finished its cycle at %0t", $time);
        end
        reen = make_row(4'b0001, 4'h0, 4'b0001, {8'h00, 8'h00, 8'h00, 8'h80}, 32'hf,
                        {2'd0, 2'd0, 2'd0, 2'd1}, 32'h0);
        do_beats(0, reen);
    endtask

    function automatic bit logs_match();
        if (ack_log.size() != exp_log.size()) return 1'b0;
        foreach (ack_log[k]) begin
            if (ack_log[k] != exp_log[k]) return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD);
        $display("Watchdog expired before all %0d table rows completed", NUM_ROWS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        foreach (m_req[k]) m_req[k] = '0;
        lcg_state  = 32'hc41f;
        en_model   = 4'hf;
        lrg_order  = '{0, 1, 2, 3};
        cnt_model  = '{default: 0};
        cnt_snap   = '{default: 0};
        done       = 4'h0;
        data_errs  = 0;
        lat_errs   = 0;
        order_errs = 0;
        other_errs = 0;

        // All four at once, then a second round, then single-master bursts
        rows.push_back(make_row(4'hf, 4'h0, 4'hf, {8'h30, 8'h20, 8'h10, 8'h00}, 32'h0,
                                {2'd1, 2'd1, 2'd1, 2'd1}, 32'h0));
        rows.push_back(make_row(4'hf, 4'h0, 4'h0, {8'h30, 8'h20, 8'h10, 8'h00}, 32'h0,
                                {2'd1, 2'd1, 2'd1, 2'd1}, 32'h0));
        rows.push_back(make_row(4'h1, 4'h0, 4'h1, {8'h00, 8'h00, 8'h00, 8'h04}, 32'h0,
                                {2'd0, 2'd0, 2'd0, 2'd3}, 32'h0));
        rows.push_back(make_row(4'h1, 4'h0, 4'h0, {8'h00, 8'h00, 8'h00, 8'h04}, 32'h0,
                                {2'd0, 2'd0, 2'd0, 2'd3}, 32'h0));
        // Master 1 holds three beats against the others
        rows.push_back(make_row(4'hf, 4'h0, 4'hf, {8'h38, 8'h28, 8'h08, 8'h18}, 32'h0,
                                {2'd1, 2'd1, 2'd3, 2'd1}, 32'h0));
        rows.push_back(make_row(4'h4, 4'h0, 4'h0, {8'h00, 8'h08, 8'h00, 8'h00}, 32'h0,
                                {2'd0, 2'd3, 2'd0, 2'd0}, 32'h0));
        // Disable master 2, then all four request
        rows.push_back(make_row(4'h1, 4'h0, 4'h1, {8'h00, 8'h00, 8'h00, 8'h80}, 32'hb,
                                {2'd0, 2'd0, 2'd0, 2'd1}, 32'h0));
        rows.push_back(make_row(4'hf, 4'h4, 4'hf, {8'h3c, 8'h2c, 8'h1c, 8'h0c}, 32'h0,
                                {2'd1, 2'd1, 2'd1, 2'd1}, 32'h0));
        rows.push_back(make_row(4'h8, 4'h0, 4'h0, {8'h2c, 8'h00, 8'h00, 8'h00}, 32'h0,
                                {2'd1, 2'd0, 2'd0, 2'd0}, 32'h0));
        for (int k = 1; k <= 4; k++) begin
            rows.push_back(make_row(4'h8, 4'h0, 4'h0, {8'(8'h80 + k), 8'h00, 8'h00, 8'h00},
                                    32'h0, {2'd1, 2'd0, 2'd0, 2'd0}, 32'h0));
        end
        rows.push_back(make_row(4'h2, 4'h0, 4'h0, {8'h00, 8'h00, 8'h85, 8'h00}, 32'h0,
                                {2'd0, 2'd0, 2'd1, 2'd0}, 32'h4152_4231));
        rows.push_back(make_row(4'h4, 4'h0, 4'h0, {8'h00, 8'h80, 8'h00, 8'h00}, 32'h0,
                                {2'd0, 2'd1, 2'd0, 2'd0}, 32'h0));

        wait (rst_n === 1'b1);
        @(negedge clk);
        foreach (rows[i]) begin
            cnt_snap = cnt_model;
            ack_log.delete();
            predict_order(rows[i]);
            done = ~rows[i].active;
            fork
                do_beats(0, rows[i]);
                do_beats(1, rows[i]);
                do_beats(2, rows[i]);
                do_beats(3, rows[i]);
                release_stalled(rows[i]);
            join
            assert (logs_match()) else begin
                order_errs++;
                $display("FAIL %0t: row %0d acks arrived out of the predicted order",
                         $time, i);
            end
            // Idle gap lets the held grant lapse before the next row
            repeat (3) @(negedge clk);
        end

        $display("Errors: data %0d, latency %0d, order %0d, other %0d",
                 data_errs, lat_errs, order_errs, other_errs);
        if (data_errs + lat_errs + order_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/wb_pkg.sv
design/arb_pkg.sv
design/matrix_arbiter.sv
design/wb_master_mux.sv
design/arb_ctrl_regs.sv
design/wb_sram.sv
design/wb_shared_bus.sv
dv/tb_clock_gen.sv
dv/wb_shared_bus_properties.sv
dv/wb_shared_bus_tb.sv
